// ==== tile_defines.svh ====
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// datapath and register file
`define XLEN     32
`define AREG_NUM 16

// execution resources
`define ALU_NUM  2
// tags wrap with the buffer so this stays a power of two
`define ROB_SIZE 8
`define MUL_LAT  4

`endif

// ==== tile_pkg.sv ====
`default_nettype none

`include "tile_defines.svh"

package tile_pkg;

  typedef enum logic [2:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_MUL
  } alu_op_e;

  typedef logic [$clog2(`AREG_NUM)-1:0] areg_t;
  typedef logic [$clog2(`ROB_SIZE)-1:0] rob_tag_t;

  // per-unit reservation slot
  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_EXEC,
    S_DONE
  } alu_state_e;

endpackage

`default_nettype wire

// ==== tile_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

interface disp_if import tile_pkg::*; ();
  // one strobe per unit, payload shared
  logic [`ALU_NUM-1:0] valid;
  alu_op_e             op;
  areg_t               rd;
  areg_t               rs1;
  areg_t               rs2;
  logic [`XLEN-1:0]    imm;
  rob_tag_t            tag;
  logic                rs1_wait;
  rob_tag_t            rs1_tag;
  logic                rs2_wait;
  rob_tag_t            rs2_tag;

  modport master (
    output valid, op, rd, rs1, rs2, imm, tag, rs1_wait, rs1_tag, rs2_wait, rs2_tag
  );
  modport slave (
    input valid, op, rd, rs1, rs2, imm, tag, rs1_wait, rs1_tag, rs2_wait, rs2_tag
  );
endinterface

interface done_if import tile_pkg::*; ();
  logic             valid;
  rob_tag_t         tag;
  logic [`XLEN-1:0] data;

  modport master (output valid, tag, data);
  modport slave  (input  valid, tag, data);
endinterface

interface cmt_if import tile_pkg::*; ();
  logic             valid;
  rob_tag_t         tag;
  areg_t            rd;
  logic [`XLEN-1:0] data;

  modport master  (output valid, tag, rd, data);
  modport monitor (input  valid, tag, rd, data);
endinterface

interface regread_if import tile_pkg::*; ();
  areg_t            rs1;
  areg_t            rs2;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;

  modport master (output rs1, rs2, input  rs1_data, rs2_data);
  modport slave  (input  rs1, rs2, output rs1_data, rs2_data);
endinterface

`default_nettype wire

// ==== tile_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

module tile_dispatch import tile_pkg::*; (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_valid,
  input  alu_op_e             i_op,
  input  areg_t               i_rd,
  input  areg_t               i_rs1,
  input  areg_t               i_rs2,
  input  logic [`XLEN-1:0]    i_imm,
  input  logic [`ALU_NUM-1:0] i_unit_busy,
  input  logic                i_rob_full,
  output logic                o_ready,
  disp_if.master              disp,
  cmt_if.monitor              cmt
);

  rob_tag_t            tail_tag;
  rob_tag_t            prod_tag [`AREG_NUM];
  logic [`AREG_NUM-1:0] pending;
  logic [`ALU_NUM-1:0] unit_free;
  logic [`ALU_NUM-1:0] unit_sel;
  logic                fire;
  logic                use_rs1;
  logic                use_rs2;

  assign unit_free = ~i_unit_busy;
  // lowest idle unit, one-hot
  assign unit_sel  = unit_free & (~unit_free + 1'b1);

  assign o_ready = (|unit_free) & ~i_rob_full;
  assign fire    = i_valid & o_ready;

  assign use_rs1 = (i_op != OP_LI);
  assign use_rs2 = (i_op != OP_LI) && (i_op != OP_ADDI);

  assign disp.valid = fire ? unit_sel : '0;
  assign disp.op    = i_op;
  assign disp.rd    = i_rd;
  assign disp.rs1   = i_rs1;
  assign disp.rs2   = i_rs2;
  assign disp.imm   = i_imm;
  assign disp.tag   = tail_tag;

  // a producer committing right now no longer needs waiting on
  assign disp.rs1_tag  = prod_tag[i_rs1];
  assign disp.rs1_wait = use_rs1 && pending[i_rs1] &&
                         !(cmt.valid && cmt.tag == prod_tag[i_rs1]);
  assign disp.rs2_tag  = prod_tag[i_rs2];
  assign disp.rs2_wait = use_rs2 && pending[i_rs2] &&
                         !(cmt.valid && cmt.tag == prod_tag[i_rs2]);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      tail_tag <= '0;
      pending  <= '0;
    end else begin
      for (int r = 0; r < `AREG_NUM; r++) begin
        if (cmt.valid && pending[r] && prod_tag[r] == cmt.tag) begin
          pending[r] <= 1'b0;
        end
      end
      // new producer wins over a same-cycle clear
      if (fire) begin
        pending[i_rd] <= 1'b1;
        tail_tag      <= tail_tag + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (fire) begin
      prod_tag[i_rd] <= tail_tag;
    end
  end

  a_valid_only_when_ready : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_valid |-> o_ready
  ) else $error("dispatch strobe while not ready");

endmodule

`default_nettype wire

// ==== tile_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

module tile_alu import tile_pkg::*; #(
  parameter int UNIT_ID = 0
) (
  input  logic       i_clk,
  input  logic       i_rst_n,
  output logic       o_busy,
  disp_if.slave      disp,
  cmt_if.monitor     cmt,
  regread_if.master  regread,
  done_if.master     done
);

  localparam int CNT_W = $clog2(`MUL_LAT);

  alu_state_e       state;
  logic             accept;
  logic             wait1;
  logic             wait2;
  logic             wait1_nxt;
  logic             wait2_nxt;
  logic [CNT_W-1:0] cnt;

  alu_op_e          op_q;
  logic [`XLEN-1:0] imm_q;
  rob_tag_t         tag_q;
  areg_t            rs1_q;
  areg_t            rs2_q;
  rob_tag_t         rs1_tag_q;
  rob_tag_t         rs2_tag_q;
  logic [`XLEN-1:0] res_q;
  logic [`XLEN-1:0] alu_res;

  assign accept = (state == S_IDLE) && disp.valid[UNIT_ID];
  assign o_busy = (state != S_IDLE);

  // producer commit releases the operand
  assign wait1_nxt = wait1 && !(cmt.valid && cmt.tag == rs1_tag_q);
  assign wait2_nxt = wait2 && !(cmt.valid && cmt.tag == rs2_tag_q);

  assign regread.rs1 = rs1_q;
  assign regread.rs2 = rs2_q;

  always_comb begin
    case (op_q)
      OP_LI:   alu_res = imm_q;
      OP_ADD:  alu_res = regread.rs1_data + regread.rs2_data;
      OP_SUB:  alu_res = regread.rs1_data - regread.rs2_data;
      OP_AND:  alu_res = regread.rs1_data & regread.rs2_data;
      OP_OR:   alu_res = regread.rs1_data | regread.rs2_data;
      OP_XOR:  alu_res = regread.rs1_data ^ regread.rs2_data;
      OP_ADDI: alu_res = regread.rs1_data + imm_q;
      OP_MUL:  alu_res = regread.rs1_data * regread.rs2_data;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= S_IDLE;
      wait1 <= 1'b0;
      wait2 <= 1'b0;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            wait1 <= disp.rs1_wait;
            wait2 <= disp.rs2_wait;
            cnt   <= (disp.op == OP_MUL) ? CNT_W'(`MUL_LAT - 1) : '0;
            state <= (disp.rs1_wait || disp.rs2_wait) ? S_WAIT : S_EXEC;
          end
        end
        S_WAIT: begin
          wait1 <= wait1_nxt;
          wait2 <= wait2_nxt;
          if (!wait1_nxt && !wait2_nxt) begin
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (cnt == '0) begin
            state <= S_DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        S_DONE:  state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      op_q      <= disp.op;
      imm_q     <= disp.imm;
      tag_q     <= disp.tag;
      rs1_q     <= disp.rs1;
      rs2_q     <= disp.rs2;
      rs1_tag_q <= disp.rs1_tag;
      rs2_tag_q <= disp.rs2_tag;
    end
    // last exec cycle
    if (state == S_EXEC && cnt == '0) begin
      res_q <= alu_res;
    end
  end

  assign done.valid = (state == S_DONE);
  assign done.tag   = tag_q;
  assign done.data  = res_q;

  a_no_strobe_when_busy : assert property (
    @(posedge i_clk) disable iff (!i_rst_n) disp.valid[UNIT_ID] |-> state == S_IDLE
  ) else $error("unit %0d strobed while busy", UNIT_ID);

endmodule

`default_nettype wire

// ==== tile_rob.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

module tile_rob import tile_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_alloc,
  input  areg_t i_alloc_rd,
  output logic  o_full,
  done_if.slave done [`ALU_NUM],
  cmt_if.master cmt
);

  localparam int CNT_W = $clog2(`ROB_SIZE) + 1;

  logic [`ROB_SIZE-1:0] ent_valid;
  logic [`ROB_SIZE-1:0] ent_done;
  areg_t                ent_rd   [`ROB_SIZE];
  logic [`XLEN-1:0]     ent_data [`ROB_SIZE];
  rob_tag_t             head;
  rob_tag_t             tail;
  logic [CNT_W-1:0]     count;

  logic [`ALU_NUM-1:0]  done_valid;
  rob_tag_t             done_tag  [`ALU_NUM];
  logic [`XLEN-1:0]     done_data [`ALU_NUM];

  for (genvar g = 0; g < `ALU_NUM; g++) begin : done_loop
    assign done_valid[g] = done[g].valid;
    assign done_tag[g]   = done[g].tag;
    assign done_data[g]  = done[g].data;

    a_done_targets_live : assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      done_valid[g] |-> ent_valid[done_tag[g]] && !ent_done[done_tag[g]]
    ) else $error("completion from unit %0d hits a dead or finished entry", g);
  end

  assign o_full = (count == CNT_W'(`ROB_SIZE));

  // head retires as soon as its result is in
  assign cmt.valid = ent_valid[head] & ent_done[head];
  assign cmt.tag   = head;
  assign cmt.rd    = ent_rd[head];
  assign cmt.data  = ent_data[head];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (i_alloc) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1;
      end
      for (int i = 0; i < `ALU_NUM; i++) begin
        if (done_valid[i]) begin
          ent_done[done_tag[i]] <= 1'b1;
        end
      end
      if (cmt.valid) begin
        ent_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
      case ({i_alloc, cmt.valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
    for (int i = 0; i < `ALU_NUM; i++) begin
      if (done_valid[i]) begin
        ent_data[done_tag[i]] <= done_data[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== tile_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

module tile_regfile import tile_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst_n,
  regread_if.slave rd_port [`ALU_NUM],
  cmt_if.monitor   cmt
);

  logic [`XLEN-1:0] regs [`AREG_NUM];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int r = 0; r < `AREG_NUM; r++) begin
        regs[r] <= '0;
      end
    end else if (cmt.valid) begin
      regs[cmt.rd] <= cmt.data;
    end
  end

  // same-cycle commit is visible on the read ports
  for (genvar g = 0; g < `ALU_NUM; g++) begin : rd_loop
    assign rd_port[g].rs1_data = (cmt.valid && cmt.rd == rd_port[g].rs1) ?
                                 cmt.data : regs[rd_port[g].rs1];
    assign rd_port[g].rs2_data = (cmt.valid && cmt.rd == rd_port[g].rs2) ?
                                 cmt.data : regs[rd_port[g].rs2];
  end

endmodule

`default_nettype wire

// ==== tile_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

module tile_core import tile_pkg::*; (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_disp_valid,
  input  alu_op_e          i_disp_op,
  input  areg_t            i_disp_rd,
  input  areg_t            i_disp_rs1,
  input  areg_t            i_disp_rs2,
  input  logic [`XLEN-1:0] i_disp_imm,
  output logic             o_disp_ready,
  output logic             o_cmt_valid,
  output areg_t            o_cmt_rd,
  output logic [`XLEN-1:0] o_cmt_data
);

  disp_if    w_disp ();
  cmt_if     w_cmt ();
  done_if    w_done    [`ALU_NUM] ();
  regread_if w_regread [`ALU_NUM] ();

  logic [`ALU_NUM-1:0] w_unit_busy;
  logic                w_rob_full;
  logic                w_alloc;

  // any unit strobe means one new ROB entry
  assign w_alloc = |w_disp.valid;

  tile_dispatch u_dispatch (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_disp_valid),
    .i_op        (i_disp_op),
    .i_rd        (i_disp_rd),
    .i_rs1       (i_disp_rs1),
    .i_rs2       (i_disp_rs2),
    .i_imm       (i_disp_imm),
    .i_unit_busy (w_unit_busy),
    .i_rob_full  (w_rob_full),
    .o_ready     (o_disp_ready),
    .disp        (w_disp),
    .cmt         (w_cmt)
  );

  for (genvar alu_idx = 0; alu_idx < `ALU_NUM; alu_idx++) begin : alu_loop
    tile_alu #(
      .UNIT_ID (alu_idx)
    ) u_alu (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .o_busy  (w_unit_busy[alu_idx]),
      .disp    (w_disp),
      .cmt     (w_cmt),
      .regread (w_regread[alu_idx]),
      .done    (w_done[alu_idx])
    );
  end

  tile_rob u_rob (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_alloc    (w_alloc),
    .i_alloc_rd (w_disp.rd),
    .o_full     (w_rob_full),
    .done       (w_done),
    .cmt        (w_cmt)
  );

  tile_regfile u_regfile (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .rd_port (w_regread),
    .cmt     (w_cmt)
  );

  assign o_cmt_valid = w_cmt.valid;
  assign o_cmt_rd    = w_cmt.rd;
  assign o_cmt_data  = w_cmt.data;

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // released on a rising edge once the reset cycles are over
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_tile_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tile_defines.svh"

module tb_tile_core import tile_pkg::*; ();

  localparam int MAX_CASES = 64;

  logic             clk;
  logic             rst_n;
  logic             disp_valid;
  alu_op_e          disp_op;
  areg_t            disp_rd;
  areg_t            disp_rs1;
  areg_t            disp_rs2;
  logic [`XLEN-1:0] disp_imm;
  logic             disp_ready;
  logic             cmt_valid;
  areg_t            cmt_rd;
  logic [`XLEN-1:0] cmt_data;

  string            case_name [MAX_CASES];
  alu_op_e          case_op   [MAX_CASES];
  areg_t            case_rd   [MAX_CASES];
  areg_t            case_rs1  [MAX_CASES];
  areg_t            case_rs2  [MAX_CASES];
  logic [`XLEN-1:0] case_imm  [MAX_CASES];
  logic [`XLEN-1:0] case_exp  [MAX_CASES];
  int               num_cases;

  int               cmt_idx;
  int               pass_count;
  int               fail_count;
  bit               saw_stall;
  bit               cases_loaded;

  tb_clkgen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (3)
  ) u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  tile_core uut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_disp_valid (disp_valid),
    .i_disp_op    (disp_op),
    .i_disp_rd    (disp_rd),
    .i_disp_rs1   (disp_rs1),
    .i_disp_rs2   (disp_rs2),
    .i_disp_imm   (disp_imm),
    .o_disp_ready (disp_ready),
    .o_cmt_valid  (cmt_valid),
    .o_cmt_rd     (cmt_rd),
    .o_cmt_data   (cmt_data)
  );

  function automatic bit op_from_name(input string name, output alu_op_e op);
    op = OP_LI;
    case (name)
      "LI":    op = OP_LI;
      "ADD":   op = OP_ADD;
      "SUB":   op = OP_SUB;
      "AND":   op = OP_AND;
      "OR":    op = OP_OR;
      "XOR":   op = OP_XOR;
      "ADDI":  op = OP_ADDI;
      "MUL":   op = OP_MUL;
      default: return 1'b0;
    endcase
    return 1'b1;
  endfunction

  task automatic load_cases(output bit ok);
    int               fd;
    int               got;
    int               n;
    string            line;
    string            name;
    string            op_name;
    int               rd;
    int               rs1;
    int               rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] exp_val;
    alu_op_e          op;
    ok        = 1'b1;
    num_cases = 0;
    fd = $fopen("tile_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open tile_cases.txt");
      ok = 1'b0;
      return;
    end
    while (!$feof(fd) && ok) begin
      line = "";
      got  = $fgets(line, fd);
      // skip comments and empty lines
      if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %d %d %d %h %h", name, op_name, rd, rs1, rs2, imm, exp_val);
        if (n != 7) begin
          $display("malformed line in tile_cases.txt: %s", line);
          ok = 1'b0;
        end else if (!op_from_name(op_name, op)) begin
          $display("unknown opcode %s in case %s", op_name, name);
          ok = 1'b0;
        end else if (num_cases >= MAX_CASES) begin
          $display("too many cases in tile_cases.txt");
          ok = 1'b0;
        end else begin
          case_name[num_cases] = name;
          case_op[num_cases]   = op;
          case_rd[num_cases]   = areg_t'(rd);
          case_rs1[num_cases]  = areg_t'(rs1);
          case_rs2[num_cases]  = areg_t'(rs2);
          case_imm[num_cases]  = imm;
          case_exp[num_cases]  = exp_val;
          num_cases++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_reset_state();
    if (cmt_valid !== 1'b0 || disp_ready !== 1'b1) begin
      $display("FAILED reset_state: expected valid 0 ready 1, actual valid %b ready %b",
               cmt_valid, disp_ready);
      fail_count++;
    end else begin
      $display("ok     reset_state");
      pass_count++;
    end
  endtask

  task automatic check_stall_seen();
    if (!saw_stall) begin
      $display("FAILED dispatch_stall: expected ready 0 at least once, actual always 1");
      fail_count++;
    end else begin
      $display("ok     dispatch_stall");
      pass_count++;
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  initial begin
    bit   load_ok;
    int   idx;
    logic can_send;
    disp_valid   <= 1'b0;
    disp_op      <= OP_LI;
    disp_rd      <= '0;
    disp_rs1     <= '0;
    disp_rs2     <= '0;
    disp_imm     <= '0;
    cmt_idx      = 0;
    pass_count   = 0;
    fail_count   = 0;
    saw_stall    = 1'b0;
    cases_loaded = 1'b0;
    load_cases(load_ok);
    cases_loaded = 1'b1;
    if (!load_ok) begin
      $display("could not read the cases from tile_cases.txt");
      fail_count++;
    end else begin
      wait (rst_n === 1'b1);
      @(negedge clk);
      check_reset_state();
      idx = 0;
      while (idx < num_cases) begin
        // ready only falls after a dispatch so the cycle after one is skipped
        @(negedge clk);
        can_send = disp_ready && !disp_valid;
        @(posedge clk);
        if (can_send) begin
          disp_valid <= 1'b1;
          disp_op    <= case_op[idx];
          disp_rd    <= case_rd[idx];
          disp_rs1   <= case_rs1[idx];
          disp_rs2   <= case_rs2[idx];
          disp_imm   <= case_imm[idx];
          idx++;
        end else begin
          disp_valid <= 1'b0;
        end
      end
      @(posedge clk);
      disp_valid <= 1'b0;
      wait (cmt_idx == num_cases);
      // a few idle cycles to catch stray commits
      repeat (10) @(negedge clk);
      check_stall_seen();
    end
    finish_run();
  end

  // commit monitor samples mid-cycle where the outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (!disp_ready) begin
        saw_stall = 1'b1;
      end
      if (cmt_valid) begin
        if (cmt_idx >= num_cases) begin
          $display("a commit arrived after every case had already committed");
          fail_count++;
        end else begin
          if (cmt_rd !== case_rd[cmt_idx] || cmt_data !== case_exp[cmt_idx]) begin
            $display("FAILED %s: expected rd %0d data %h, actual rd %0d data %h",
                     case_name[cmt_idx], case_rd[cmt_idx], case_exp[cmt_idx],
                     cmt_rd, cmt_data);
            fail_count++;
          end else begin
            $display("ok     %s: rd %0d data %h", case_name[cmt_idx], cmt_rd, cmt_data);
            pass_count++;
          end
          cmt_idx++;
        end
      end
    end
  end

  initial begin
    wait (cases_loaded);
    repeat (20 * num_cases + 50) @(posedge clk);
    $display("timeout: commits stopped after %0d of %0d cases", cmt_idx, num_cases);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tile_cases.txt ====
# name op rd rs1 rs2 imm(hex) expected(hex)
# rd and rs are decimal, all registers start at zero
li_a       LI   1  0  0  00000005 00000005
li_b       LI   2  0  0  00000003 00000003
li_c       LI   3  0  0  f0f000ff f0f000ff
add_ab     ADD  4  1  2  00000000 00000008
sub_ab     SUB  5  1  2  00000000 00000002
and_cb     AND  6  3  2  00000000 00000003
or_ca      OR   7  3  1  00000000 f0f000ff
xor_ca     XOR  8  3  1  00000000 f0f000fa
sub_neg    SUB  9  2  1  00000000 fffffffe
addi_1     ADDI 10 10 0  00000007 00000007
addi_2     ADDI 10 10 0  00000010 00000017
add_raw    ADD  11 10 4  00000000 0000001f
xor_raw    XOR  12 11 10 00000000 00000008
mul_ab     MUL  13 1  3  00000000 b4b004fb
li_fast    LI   14 0  0  00001234 00001234
addi_fast  ADDI 15 2  0  00000001 00000004
war_read   ADD  1  1  2  00000000 00000008
war_write  LI   2  0  0  00000100 00000100
waw_first  ADDI 6  2  0  00000001 00000101
waw_second LI   6  0  0  00000055 00000055
waw_use    ADD  7  6  1  00000000 0000005d
mul_1      MUL  8  2  2  00000000 00010000
mul_2      MUL  9  1  1  00000000 00000040
mul_3      MUL  10 8  9  00000000 00400000
li_end     LI   0  0  0  0000dead 0000dead
addi_neg   ADDI 11 14 0  ffffffff 00001233

// ==== vlog.f ====
+incdir+.
tile_pkg.sv
tile_ifs.sv
tile_dispatch.sv
tile_alu.sv
tile_rob.sv
tile_regfile.sv
tile_core.sv
tb_clkgen.sv
tb_tile_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tile testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_tile_core -o tb_tile_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_tile_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
